// ==== hw/redmule_params.svh ====
`ifndef REDMULE_PARAMS_SVH
`define REDMULE_PARAMS_SVH

// Element and array geometry
`define REDMULE_ELEM_W 16
`define REDMULE_ARRAY_W 4
`define REDMULE_ARRAY_H 4

// Memory master port, one word holds four elements
`define REDMULE_MEM_DW 64
`define REDMULE_MEM_AW 32

// Width of the inner dimension register
`define REDMULE_SIZE_W 16

// Register slave port
`define REDMULE_PERIPH_AW 8
`define REDMULE_PERIPH_DW 32

`endif

// ==== hw/redmule_pkg.sv ====
`include "redmule_params.svh"

package redmule_pkg;

  // Byte offsets of the register slave
  typedef enum logic [`REDMULE_PERIPH_AW-1:0] {
    REG_X_ADDR  = 8'h00,
    REG_W_ADDR  = 8'h04,
    REG_Z_ADDR  = 8'h08,
    REG_N_SIZE  = 8'h0C,
    REG_TRIGGER = 8'h10,
    REG_STATUS  = 8'h14
  } redmule_reg_e;

  // Job descriptor captured at trigger
  typedef struct packed {
    logic [`REDMULE_MEM_AW-1:0] x_addr;
    logic [`REDMULE_MEM_AW-1:0] w_addr;
    logic [`REDMULE_MEM_AW-1:0] z_addr;
    logic [`REDMULE_SIZE_W-1:0] n_size;
  } redmule_job_t;

  typedef enum logic {
    CTRL_IDLE,
    CTRL_RUN
  } ctrl_state_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ_X,
    ST_WAIT_X,
    ST_READ_W,
    ST_WAIT_W,
    ST_PUSH,
    ST_STORE,
    ST_DONE
  } streamer_state_e;

endpackage

// ==== hw/redmule_stream_if.sv ====
`include "redmule_params.svh"

// One memory word per transfer, taken when valid and ready are both high
interface redmule_stream_if;

  logic                       valid;
  logic                       ready;
  logic [`REDMULE_MEM_DW-1:0] data;
  logic                       last;

  modport source (
    output valid, data, last,
    input  ready
  );

  modport sink (
    input  valid, data, last,
    output ready
  );

endinterface

// ==== hw/redmule_ctrl.sv ====
`include "redmule_params.svh"

module redmule_ctrl (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          periph_req_i,
  input  logic                          periph_wen_i,
  input  logic [`REDMULE_PERIPH_AW-1:0] periph_add_i,
  input  logic [`REDMULE_PERIPH_DW-1:0] periph_data_i,
  output logic                          periph_gnt_o,
  output logic [`REDMULE_PERIPH_DW-1:0] periph_r_data_o,
  output logic                          periph_r_valid_o,
  input  logic                          done_i,
  output logic                          start_o,
  output redmule_pkg::redmule_job_t     job_o,
  output logic                          busy_o,
  output logic                          evt_o
);

  redmule_pkg::ctrl_state_e      state_q;
  redmule_pkg::redmule_reg_e     reg_sel;
  logic [`REDMULE_MEM_AW-1:0]    x_addr_q, w_addr_q, z_addr_q;
  logic [`REDMULE_SIZE_W-1:0]    n_size_q;
  logic [`REDMULE_PERIPH_DW-1:0] r_data_d;
  logic                          wr_en, rd_en;

  // Every request is granted at once
  assign periph_gnt_o = periph_req_i;
  assign wr_en        = periph_req_i && !periph_wen_i;
  assign rd_en        = periph_req_i && periph_wen_i;
  assign reg_sel      = redmule_pkg::redmule_reg_e'(periph_add_i);

  assign busy_o  = (state_q == redmule_pkg::CTRL_RUN);
  assign start_o = wr_en && (reg_sel == redmule_pkg::REG_TRIGGER) && !busy_o;

  always_comb begin
    case (reg_sel)
      redmule_pkg::REG_X_ADDR: r_data_d = x_addr_q;
      redmule_pkg::REG_W_ADDR: r_data_d = w_addr_q;
      redmule_pkg::REG_Z_ADDR: r_data_d = z_addr_q;
      redmule_pkg::REG_N_SIZE: r_data_d = `REDMULE_PERIPH_DW'(n_size_q);
      redmule_pkg::REG_STATUS: r_data_d = `REDMULE_PERIPH_DW'(busy_o);
      default:                 r_data_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q          <= redmule_pkg::CTRL_IDLE;
      evt_o            <= 1'b0;
      periph_r_valid_o <= 1'b0;
      x_addr_q         <= '0;
      w_addr_q         <= '0;
      z_addr_q         <= '0;
      n_size_q         <= '0;
    end else begin
      periph_r_valid_o <= rd_en;
      evt_o            <= 1'b0;
      if (wr_en) begin
        case (reg_sel)
          redmule_pkg::REG_X_ADDR: x_addr_q <= periph_data_i[`REDMULE_MEM_AW-1:0];
          redmule_pkg::REG_W_ADDR: w_addr_q <= periph_data_i[`REDMULE_MEM_AW-1:0];
          redmule_pkg::REG_Z_ADDR: z_addr_q <= periph_data_i[`REDMULE_MEM_AW-1:0];
          redmule_pkg::REG_N_SIZE: n_size_q <= periph_data_i[`REDMULE_SIZE_W-1:0];
          default: ;
        endcase
      end
      if (start_o) begin
        state_q <= redmule_pkg::CTRL_RUN;
      end else if (busy_o && done_i) begin
        // Event goes out together with the falling busy
        state_q <= redmule_pkg::CTRL_IDLE;
        evt_o   <= 1'b1;
      end
    end
  end

  // Read data and job snapshot
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      periph_r_data_o <= r_data_d;
    end
    if (start_o) begin
      job_o <= '{x_addr: x_addr_q, w_addr: w_addr_q, z_addr: z_addr_q, n_size: n_size_q};
    end
  end

endmodule

// ==== hw/redmule_streamer.sv ====
`include "redmule_params.svh"

module redmule_streamer (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       start_i,
  input  redmule_pkg::redmule_job_t  job_i,
  output logic                       done_o,
  redmule_stream_if.source           x_o,
  redmule_stream_if.source           w_o,
  redmule_stream_if.sink             z_i,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [`REDMULE_MEM_AW-1:0] mem_addr_o,
  output logic [`REDMULE_MEM_DW-1:0] mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  logic [`REDMULE_MEM_DW-1:0] mem_rdata_i
);

  localparam int unsigned ROW_W = $clog2(`REDMULE_ARRAY_W);
  localparam logic [`REDMULE_MEM_AW-1:0] STRIDE = `REDMULE_MEM_DW / 8;

  redmule_pkg::streamer_state_e state_q, state_d;
  logic [`REDMULE_SIZE_W-1:0]   step_q, last_idx;
  logic [ROW_W-1:0]             row_q;
  logic [`REDMULE_MEM_DW-1:0]   x_data_q, w_data_q;
  logic [`REDMULE_MEM_AW-1:0]   step_off, row_off;
  logic                         last_step, pair_take, z_take;

  // N of zero runs a single step
  assign last_idx  = (job_i.n_size == '0) ? '0 : job_i.n_size - `REDMULE_SIZE_W'(1);
  assign last_step = (step_q == last_idx);
  assign step_off  = `REDMULE_MEM_AW'(step_q) * STRIDE;
  assign row_off   = `REDMULE_MEM_AW'(row_q) * STRIDE;

  // Both operands are offered together
  assign x_o.valid = (state_q == redmule_pkg::ST_PUSH);
  assign w_o.valid = (state_q == redmule_pkg::ST_PUSH);
  assign x_o.data  = x_data_q;
  assign w_o.data  = w_data_q;
  assign x_o.last  = last_step;
  assign w_o.last  = last_step;
  assign pair_take = x_o.valid && x_o.ready && w_o.ready;
  assign z_take    = (state_q == redmule_pkg::ST_STORE) && z_i.valid && mem_gnt_i;

  always_comb begin
    state_d     = state_q;
    mem_req_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = '0;
    mem_wdata_o = '0;
    z_i.ready   = 1'b0;
    done_o      = 1'b0;
    case (state_q)
      redmule_pkg::ST_IDLE:   if (start_i) state_d = redmule_pkg::ST_READ_X;
      redmule_pkg::ST_READ_X: begin
        mem_req_o  = 1'b1;
        mem_addr_o = job_i.x_addr + step_off;
        if (mem_gnt_i) state_d = redmule_pkg::ST_WAIT_X;
      end
      redmule_pkg::ST_WAIT_X: if (mem_rvalid_i) state_d = redmule_pkg::ST_READ_W;
      redmule_pkg::ST_READ_W: begin
        mem_req_o  = 1'b1;
        mem_addr_o = job_i.w_addr + step_off;
        if (mem_gnt_i) state_d = redmule_pkg::ST_WAIT_W;
      end
      redmule_pkg::ST_WAIT_W: if (mem_rvalid_i) state_d = redmule_pkg::ST_PUSH;
      redmule_pkg::ST_PUSH: begin
        if (pair_take) state_d = last_step ? redmule_pkg::ST_STORE : redmule_pkg::ST_READ_X;
      end
      redmule_pkg::ST_STORE: begin
        // Row is popped from the engine only on the memory grant
        mem_req_o   = z_i.valid;
        mem_we_o    = 1'b1;
        mem_addr_o  = job_i.z_addr + row_off;
        mem_wdata_o = z_i.data;
        z_i.ready   = mem_gnt_i;
        if (z_take && z_i.last) state_d = redmule_pkg::ST_DONE;
      end
      redmule_pkg::ST_DONE: begin
        done_o  = 1'b1;
        state_d = redmule_pkg::ST_IDLE;
      end
      default: state_d = redmule_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= redmule_pkg::ST_IDLE;
      step_q  <= '0;
      row_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start_i && state_q == redmule_pkg::ST_IDLE) begin
        step_q <= '0;
        row_q  <= '0;
      end else begin
        if (pair_take && !last_step) step_q <= step_q + `REDMULE_SIZE_W'(1);
        if (z_take) row_q <= row_q + ROW_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == redmule_pkg::ST_WAIT_X && mem_rvalid_i) x_data_q <= mem_rdata_i;
    if (state_q == redmule_pkg::ST_WAIT_W && mem_rvalid_i) w_data_q <= mem_rdata_i;
  end

endmodule

// ==== hw/redmule_engine.sv ====
`include "redmule_params.svh"

module redmule_engine (
  input  logic             clk_i,
  input  logic             arst_n_i,
  redmule_stream_if.sink   x_i,
  redmule_stream_if.sink   w_i,
  redmule_stream_if.source z_o
);

  localparam int unsigned EW    = `REDMULE_ELEM_W;
  localparam int unsigned ROW_W = $clog2(`REDMULE_ARRAY_W);

  logic [EW-1:0]              acc_q  [`REDMULE_ARRAY_W][`REDMULE_ARRAY_H];
  logic [EW-1:0]              x_elem [`REDMULE_ARRAY_W];
  logic [EW-1:0]              w_elem [`REDMULE_ARRAY_H];
  logic [`REDMULE_MEM_DW-1:0] z_data;
  logic [ROW_W-1:0]           row_q;
  logic                       out_active_q, first_q;
  logic                       pair_take, pair_last, z_take;

  // Operands are held off while the result rows drain
  assign x_i.ready = !out_active_q;
  assign w_i.ready = !out_active_q;
  assign pair_take = x_i.valid && w_i.valid && !out_active_q;
  assign pair_last = x_i.last && w_i.last;

  always_comb begin
    for (int r = 0; r < `REDMULE_ARRAY_W; r++) begin
      x_elem[r] = x_i.data[r*EW +: EW];
    end
    for (int c = 0; c < `REDMULE_ARRAY_H; c++) begin
      w_elem[c] = w_i.data[c*EW +: EW];
      z_data[c*EW +: EW] = acc_q[row_q][c];
    end
  end

  assign z_o.valid = out_active_q;
  assign z_o.data  = z_data;
  assign z_o.last  = (row_q == ROW_W'(`REDMULE_ARRAY_W - 1));
  assign z_take    = z_o.valid && z_o.ready;

  // Outer product accumulation, products wrap to the element width
  always_ff @(posedge clk_i) begin
    if (pair_take) begin
      for (int r = 0; r < `REDMULE_ARRAY_W; r++) begin
        for (int c = 0; c < `REDMULE_ARRAY_H; c++) begin
          if (first_q) acc_q[r][c] <= EW'(x_elem[r] * w_elem[c]);
          else acc_q[r][c] <= EW'(acc_q[r][c] + x_elem[r] * w_elem[c]);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_active_q <= 1'b0;
      first_q      <= 1'b1;
      row_q        <= '0;
    end else begin
      if (pair_take) begin
        // Next pair after the last one opens a new job
        first_q <= pair_last;
        if (pair_last) begin
          out_active_q <= 1'b1;
          row_q        <= '0;
        end
      end else if (z_take) begin
        if (z_o.last) out_active_q <= 1'b0;
        else row_q <= row_q + ROW_W'(1);
      end
    end
  end

endmodule

// ==== hw/redmule_top.sv ====
`include "redmule_params.svh"

module redmule_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          periph_req_i,
  input  logic                          periph_wen_i,
  input  logic [`REDMULE_PERIPH_AW-1:0] periph_add_i,
  input  logic [`REDMULE_PERIPH_DW-1:0] periph_data_i,
  output logic                          periph_gnt_o,
  output logic [`REDMULE_PERIPH_DW-1:0] periph_r_data_o,
  output logic                          periph_r_valid_o,
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [`REDMULE_MEM_AW-1:0]    mem_addr_o,
  output logic [`REDMULE_MEM_DW-1:0]    mem_wdata_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  logic [`REDMULE_MEM_DW-1:0]    mem_rdata_i,
  output logic                          busy_o,
  output logic                          evt_o
);

  redmule_pkg::redmule_job_t job;
  logic                      start, done;

  // Operand streams towards the engine, result rows back to memory
  redmule_stream_if x_stream ();
  redmule_stream_if w_stream ();
  redmule_stream_if z_stream ();

  redmule_ctrl i_ctrl (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .periph_req_i     ( periph_req_i     ),
    .periph_wen_i     ( periph_wen_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_data_i    ( periph_data_i    ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_r_data_o  ( periph_r_data_o  ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .done_i           ( done             ),
    .start_o          ( start            ),
    .job_o            ( job              ),
    .busy_o           ( busy_o           ),
    .evt_o            ( evt_o            )
  );

  redmule_streamer i_streamer (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .start_i      ( start        ),
    .job_i        ( job          ),
    .done_o       ( done         ),
    .x_o          ( x_stream     ),
    .w_o          ( w_stream     ),
    .z_i          ( z_stream     ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  )
  );

  redmule_engine i_engine (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .x_i      ( x_stream ),
    .w_i      ( w_stream ),
    .z_o      ( z_stream )
  );

endmodule

// ==== test/redmule_props.sv ====
`include "redmule_params.svh"

module redmule_props (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic                       periph_req_i,
  input logic                       periph_wen_i,
  input logic                       periph_r_valid_o,
  input logic                       mem_req_o,
  input logic                       mem_we_o,
  input logic [`REDMULE_MEM_AW-1:0] mem_addr_o,
  input logic [`REDMULE_MEM_DW-1:0] mem_wdata_o,
  input logic                       mem_gnt_i,
  input logic                       busy_o,
  input logic                       evt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Request held until granted
  mem_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)
      && $stable(mem_wdata_o))
    else $error("Memory request changed before its grant");

  read_valid_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    periph_req_i && periph_wen_i |=> periph_r_valid_o)
    else $error("periph_r_valid_o missing after a read request");

  no_stray_valid_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(periph_req_i && periph_wen_i) |=> !periph_r_valid_o)
    else $error("periph_r_valid_o without a read request");

  evt_single_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    evt_o |=> !evt_o)
    else $error("evt_o high for two cycles");

  evt_busy_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(evt_o) |-> $past(busy_o))
    else $error("evt_o rose while not busy");

endmodule

// ==== test/redmule_tb.sv ====
`include "redmule_params.svh"

module redmule_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned MAX_N        = 8;
  localparam int unsigned EW           = `REDMULE_ELEM_W;
  // One step for the register test and then N of every job in run order
  localparam int unsigned TOTAL_STEPS  = 1 + 1 + 6 + 4 + 3 + 5;

  logic                          clk_i = 1'b0;
  logic                          arst_n_i;
  logic                          periph_req_i, periph_wen_i;
  logic [`REDMULE_PERIPH_AW-1:0] periph_add_i;
  logic [`REDMULE_PERIPH_DW-1:0] periph_data_i, periph_r_data_o;
  logic                          periph_gnt_o, periph_r_valid_o;
  logic                          mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  logic [`REDMULE_MEM_AW-1:0]    mem_addr_o;
  logic [`REDMULE_MEM_DW-1:0]    mem_wdata_o, mem_rdata_i;
  logic                          busy_o, evt_o;

  logic [`REDMULE_MEM_DW-1:0] mem [logic [`REDMULE_MEM_AW-1:0]];
  logic [EW-1:0]              x_el [MAX_N][4];
  logic [EW-1:0]              w_el [MAX_N][4];
  logic                       stall_en;
  int unsigned                evt_count = 0;

  always #2 clk_i = ~clk_i;

  redmule_top redmule_top_i (.*);

  bind redmule_top redmule_props props_i (.*);

  // Untouched words read back their own address
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr, ~addr};
  endfunction

  // Memory model with read data one cycle after the grant
  always @(posedge clk_i) begin
    mem_rvalid_i <= 1'b0;
    if (mem_req_o && mem_gnt_i) begin
      if (mem_we_o) begin
        mem[mem_addr_o] = mem_wdata_o;
      end else begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= mem.exists(mem_addr_o) ? mem[mem_addr_o] : fill_word(mem_addr_o);
      end
    end
    mem_gnt_i <= !stall_en || ($urandom_range(0, 2) != 0);
  end

  always @(posedge clk_i) begin
    if (evt_o) evt_count <= evt_count + 1;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      abort_run();
    end
  endtask

  task automatic periph_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    periph_req_i  <= 1'b1;
    periph_wen_i  <= 1'b0;
    periph_add_i  <= addr;
    periph_data_i <= data;
    @(negedge clk_i);
    check_value(64'(periph_gnt_o), 64'(1), "periph_gnt_o during a write");
    @(posedge clk_i);
    periph_req_i  <= 1'b0;
  endtask

  task automatic periph_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    periph_req_i <= 1'b1;
    periph_wen_i <= 1'b1;
    periph_add_i <= addr;
    @(negedge clk_i);
    check_value(64'(periph_gnt_o), 64'(1), "periph_gnt_o during a read");
    @(posedge clk_i);
    periph_req_i <= 1'b0;
    @(negedge clk_i);
    if (!periph_r_valid_o) begin
      $display("No r_valid one cycle after the read of register %h at %0t", addr, $time);
      abort_run();
    end
    data = periph_r_data_o;
  endtask

  // Operands go to memory and the Z rows get the address pattern first
  task automatic load_operands(input int n, input logic [31:0] x_base, w_base, z_base,
                               input bit rnd);
    logic [63:0] xw, ww;
    for (int s = 0; s < n; s++) begin
      for (int e = 0; e < 4; e++) begin
        x_el[s][e] = rnd ? 16'($urandom) : 16'(e + 1);
        w_el[s][e] = rnd ? 16'($urandom) : 16'(e + 5);
        xw[16*e +: 16] = x_el[s][e];
        ww[16*e +: 16] = w_el[s][e];
      end
      mem[x_base + 32'(8 * s)] = xw;
      mem[w_base + 32'(8 * s)] = ww;
    end
    for (int r = 0; r < 4; r++) begin
      mem[z_base + 32'(8 * r)] = fill_word(z_base + 32'(8 * r));
    end
  endtask

  // Sum of outer products wrapping at 16 bits
  function automatic logic [63:0] expected_row(input int n, input int r);
    logic [63:0] row;
    logic [15:0] acc;
    for (int c = 0; c < 4; c++) begin
      acc = '0;
      for (int s = 0; s < n; s++) begin
        acc = acc + x_el[s][r] * w_el[s][c];
      end
      row[16*c +: 16] = acc;
    end
    return row;
  endfunction

  task automatic start_job(input int n, input logic [31:0] x_base, w_base, z_base);
    periph_write(redmule_pkg::REG_X_ADDR, x_base);
    periph_write(redmule_pkg::REG_W_ADDR, w_base);
    periph_write(redmule_pkg::REG_Z_ADDR, z_base);
    periph_write(redmule_pkg::REG_N_SIZE, 32'(n));
    periph_write(redmule_pkg::REG_TRIGGER, 32'd1);
  endtask

  task automatic wait_job_end(input int n, input int unsigned evt_before);
    int unsigned waited;
    waited = 0;
    while (evt_count == evt_before) begin
      @(posedge clk_i);
      waited++;
      if (waited > 200 * n) begin
        $display("evt_o did not pulse within %0d cycles of the job start", 200 * n);
        abort_run();
      end
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_value(64'(evt_count), 64'(evt_before + 1), "evt_o pulse count");
    check_value(64'(busy_o), 64'(0), "busy_o after the job");
  endtask

  task automatic check_result(input int n, input logic [31:0] z_base);
    for (int r = 0; r < 4; r++) begin
      check_value(mem[z_base + 32'(8 * r)], expected_row(n, r), $sformatf("Z row %0d", r));
    end
  endtask

  task automatic run_job(input int n, input logic [31:0] x_base, w_base, z_base,
                         input bit rnd);
    int unsigned evt_before;
    load_operands(n, x_base, w_base, z_base, rnd);
    evt_before = evt_count;
    start_job(n, x_base, w_base, z_base);
    wait_job_end(n, evt_before);
    check_result(n, z_base);
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    @(negedge clk_i);
    check_value(64'(busy_o), 64'(0), "busy_o after reset");
    check_value(64'(evt_o), 64'(0), "evt_o after reset");
    check_value(64'(mem_req_o), 64'(0), "mem_req_o after reset");
    periph_write(redmule_pkg::REG_X_ADDR, 32'h0000_1230);
    periph_write(redmule_pkg::REG_W_ADDR, 32'hA5A5_0008);
    periph_write(redmule_pkg::REG_Z_ADDR, 32'h0F0F_F0F0);
    periph_write(redmule_pkg::REG_N_SIZE, 32'h0000_BEEF);
    periph_read(redmule_pkg::REG_X_ADDR, rd);
    check_value(64'(rd), 64'h0000_1230, "REG_X_ADDR readback");
    periph_read(redmule_pkg::REG_W_ADDR, rd);
    check_value(64'(rd), 64'hA5A5_0008, "REG_W_ADDR readback");
    periph_read(redmule_pkg::REG_Z_ADDR, rd);
    check_value(64'(rd), 64'h0F0F_F0F0, "REG_Z_ADDR readback");
    periph_read(redmule_pkg::REG_N_SIZE, rd);
    check_value(64'(rd), 64'h0000_BEEF, "REG_N_SIZE readback");
    periph_read(redmule_pkg::REG_STATUS, rd);
    check_value(64'(rd), 64'(0), "REG_STATUS while idle");
    periph_read(redmule_pkg::REG_TRIGGER, rd);
    check_value(64'(rd), 64'(0), "REG_TRIGGER readback");
  endtask

  task automatic test_single_step();
    stall_en = 1'b0;
    run_job(1, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 1'b0);
  endtask

  task automatic test_random_stalls();
    stall_en = 1'b1;
    run_job(6, 32'h0000_4000, 32'h0000_5000, 32'h0000_6000, 1'b1);
  endtask

  // Second trigger lands while the first job is still running
  task automatic test_retrigger();
    logic [31:0] rd;
    int unsigned evt_before;
    stall_en = 1'b1;
    load_operands(4, 32'h0000_7000, 32'h0000_7100, 32'h0000_7200, 1'b1);
    evt_before = evt_count;
    start_job(4, 32'h0000_7000, 32'h0000_7100, 32'h0000_7200);
    periph_read(redmule_pkg::REG_STATUS, rd);
    check_value(64'(rd), 64'(1), "REG_STATUS during the job");
    // A new Z base must not reach the running job
    periph_write(redmule_pkg::REG_Z_ADDR, 32'h0000_7300);
    periph_write(redmule_pkg::REG_TRIGGER, 32'd1);
    wait_job_end(4, evt_before);
    periph_read(redmule_pkg::REG_STATUS, rd);
    check_value(64'(rd), 64'(0), "REG_STATUS after evt_o");
    periph_read(redmule_pkg::REG_Z_ADDR, rd);
    check_value(64'(rd), 64'h0000_7300, "REG_Z_ADDR written during the job");
    repeat (20) @(posedge clk_i);
    @(negedge clk_i);
    check_value(64'(evt_count), 64'(evt_before + 1), "evt_o after an ignored trigger");
    check_result(4, 32'h0000_7200);
  endtask

  task automatic test_back_to_back();
    stall_en = 1'b1;
    run_job(3, 32'h0000_8000, 32'h0000_8100, 32'h0000_9000, 1'b1);
    run_job(5, 32'h0000_8200, 32'h0000_8300, 32'h0000_9000, 1'b1);
  endtask

  initial begin
    repeat (RESET_CYCLES + 200 * TOTAL_STEPS) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", RESET_CYCLES + 200 * TOTAL_STEPS);
    abort_run();
  end

  initial begin
    void'($urandom(45968));
    arst_n_i      = 1'b0;
    periph_req_i  = 1'b0;
    periph_wen_i  = 1'b0;
    periph_add_i  = '0;
    periph_data_i = '0;
    mem_gnt_i     = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    stall_en      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    test_registers();
    test_single_step();
    test_random_stalls();
    test_retrigger();
    test_back_to_back();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/redmule_pkg.sv
hw/redmule_stream_if.sv
hw/redmule_ctrl.sv
hw/redmule_streamer.sv
hw/redmule_engine.sv
hw/redmule_top.sv
test/redmule_props.sv
test/redmule_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= redmule_tb
FILELIST  ?= project.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the Verilator model, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
